// ==== logic/rv_params.svh ====
// Width and address constants for the decode stage, included by every RTL file and the testbench
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path width
`define RV_XLEN 32

// Register index width, 32 registers
`define RV_REG_ADDR_W 5

// Halfword PC bits carried through the pipe
`define RV_PC_W 18

// Upper byte of every fetch address
`define RV_PC_BASE_HI 8'h40

`endif

// ==== logic/rv_isa_pkg.sv ====
// Instruction-side types of the decode stage, referenced by scoped name from decoder and pipe
package rv_isa_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U, IMM_NONE
    } imm_fmt_e;

    typedef enum logic [5:0] {
        UOP_NOP, UOP_ILLEGAL,
        // Register-register ALU
        UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
        UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
        // Register-immediate ALU
        UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI,
        UOP_ANDI, UOP_SLLI, UOP_SRLI, UOP_SRAI,
        // Memory
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        // Control transfer
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR,
        // Upper immediate
        UOP_LUI, UOP_AUIPC
    } uop_e;

endpackage

// ==== logic/rv_pipe_pkg.sv ====
// Pipeline-control types shared by the hazard unit, operand unit and decoder
package rv_pipe_pkg;

    // Forwarding choice per source operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // Take the register file value
        FWD_EXEC = 2'd1,  // Result leaving execute
        FWD_WB   = 2'd2   // Value being written back
    } fwd_sel_e;          // Code 3 reserved

    // What feeds value1 and value2 toward execute
    typedef enum logic [1:0] {
        OPND_REG   = 2'd0,  // rs1, rs2
        OPND_IMM   = 2'd1,  // rs1, imm
        OPND_PC    = 2'd2,  // pc, rs2
        OPND_PCIMM = 2'd3   // pc, imm
    } opnd_src_e;

endpackage

// ==== logic/instr_decoder.sv ====
// Combinational RV32I decoder giving micro-op, operand source, immediate and register fields
`timescale 1ns/100ps

`include "rv_params.svh"

module instr_decoder (
    input  logic [31:0]                 instr_i,
    output rv_isa_pkg::uop_e            uop_o,
    output rv_pipe_pkg::opnd_src_e      opnd_src_o,
    output logic [`RV_XLEN-1:0]         imm_o,
    output logic [`RV_REG_ADDR_W-1:0]   rs1_addr_o,
    output logic [`RV_REG_ADDR_W-1:0]   rs2_addr_o,
    output logic [`RV_REG_ADDR_W-1:0]   rd_addr_o
);

    rv_isa_pkg::opcode_e  opcode;
    rv_isa_pkg::imm_fmt_e imm_fmt;
    logic [2:0]           funct3;
    logic                 alt;  // funct7 bit 5 selects SUB and SRA

    assign opcode     = rv_isa_pkg::opcode_e'(instr_i[6:2]);
    assign funct3     = instr_i[14:12];
    assign alt        = instr_i[30];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    always_comb begin
        uop_o = rv_isa_pkg::UOP_ILLEGAL;  // Anything unmatched
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                case ({alt, funct3})
                    4'b0000: uop_o = rv_isa_pkg::UOP_ADD;
                    4'b1000: uop_o = rv_isa_pkg::UOP_SUB;
                    4'b0001: uop_o = rv_isa_pkg::UOP_SLL;
                    4'b0010: uop_o = rv_isa_pkg::UOP_SLT;
                    4'b0011: uop_o = rv_isa_pkg::UOP_SLTU;
                    4'b0100: uop_o = rv_isa_pkg::UOP_XOR;
                    4'b0101: uop_o = rv_isa_pkg::UOP_SRL;
                    4'b1101: uop_o = rv_isa_pkg::UOP_SRA;
                    4'b0110: uop_o = rv_isa_pkg::UOP_OR;
                    4'b0111: uop_o = rv_isa_pkg::UOP_AND;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: uop_o = rv_isa_pkg::UOP_ADDI;
                    3'b010: uop_o = rv_isa_pkg::UOP_SLTI;
                    3'b011: uop_o = rv_isa_pkg::UOP_SLTIU;
                    3'b100: uop_o = rv_isa_pkg::UOP_XORI;
                    3'b110: uop_o = rv_isa_pkg::UOP_ORI;
                    3'b111: uop_o = rv_isa_pkg::UOP_ANDI;
                    3'b001: uop_o = rv_isa_pkg::UOP_SLLI;
                    default: uop_o = alt ? rv_isa_pkg::UOP_SRAI : rv_isa_pkg::UOP_SRLI;
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: uop_o = rv_isa_pkg::UOP_LB;
                    3'b001: uop_o = rv_isa_pkg::UOP_LH;
                    3'b010: uop_o = rv_isa_pkg::UOP_LW;
                    3'b100: uop_o = rv_isa_pkg::UOP_LBU;
                    3'b101: uop_o = rv_isa_pkg::UOP_LHU;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: uop_o = rv_isa_pkg::UOP_SB;
                    3'b001: uop_o = rv_isa_pkg::UOP_SH;
                    3'b010: uop_o = rv_isa_pkg::UOP_SW;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: uop_o = rv_isa_pkg::UOP_BEQ;
                    3'b001: uop_o = rv_isa_pkg::UOP_BNE;
                    3'b100: uop_o = rv_isa_pkg::UOP_BLT;
                    3'b101: uop_o = rv_isa_pkg::UOP_BGE;
                    3'b110: uop_o = rv_isa_pkg::UOP_BLTU;
                    3'b111: uop_o = rv_isa_pkg::UOP_BGEU;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_JALR: if (funct3 == 3'b000) uop_o = rv_isa_pkg::UOP_JALR;
            rv_isa_pkg::OPC_JAL:      uop_o = rv_isa_pkg::UOP_JAL;
            rv_isa_pkg::OPC_LUI:      uop_o = rv_isa_pkg::UOP_LUI;
            rv_isa_pkg::OPC_AUIPC:    uop_o = rv_isa_pkg::UOP_AUIPC;
            rv_isa_pkg::OPC_MISC_MEM: uop_o = rv_isa_pkg::UOP_NOP;  // FENCE, FENCE.I
            rv_isa_pkg::OPC_SYSTEM:   uop_o = rv_isa_pkg::UOP_NOP;  // ECALL, EBREAK
            default: ;
        endcase
    end

    always_comb begin
        case (uop_o)
            rv_isa_pkg::UOP_ADDI, rv_isa_pkg::UOP_SLTI, rv_isa_pkg::UOP_SLTIU,
            rv_isa_pkg::UOP_XORI, rv_isa_pkg::UOP_ORI, rv_isa_pkg::UOP_ANDI,
            rv_isa_pkg::UOP_SLLI, rv_isa_pkg::UOP_SRLI, rv_isa_pkg::UOP_SRAI,
            rv_isa_pkg::UOP_LB, rv_isa_pkg::UOP_LH, rv_isa_pkg::UOP_LW,
            rv_isa_pkg::UOP_LBU, rv_isa_pkg::UOP_LHU, rv_isa_pkg::UOP_SB,
            rv_isa_pkg::UOP_SH, rv_isa_pkg::UOP_SW, rv_isa_pkg::UOP_LUI:
                opnd_src_o = rv_pipe_pkg::OPND_IMM;
            rv_isa_pkg::UOP_AUIPC, rv_isa_pkg::UOP_JAL:
                opnd_src_o = rv_pipe_pkg::OPND_PCIMM;  // Target is pc + imm
            default:
                opnd_src_o = rv_pipe_pkg::OPND_REG;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_STORE:  imm_fmt = rv_isa_pkg::IMM_S;
            rv_isa_pkg::OPC_BRANCH: imm_fmt = rv_isa_pkg::IMM_B;
            rv_isa_pkg::OPC_JAL:    imm_fmt = rv_isa_pkg::IMM_J;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:  imm_fmt = rv_isa_pkg::IMM_U;
            rv_isa_pkg::OPC_OP:     imm_fmt = rv_isa_pkg::IMM_NONE;
            default:                imm_fmt = rv_isa_pkg::IMM_I;  // Never B or J by accident
        endcase
        case (imm_fmt)
            rv_isa_pkg::IMM_I: imm_o = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
            rv_isa_pkg::IMM_S: imm_o = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25],
                                        instr_i[11:7]};
            rv_isa_pkg::IMM_B: imm_o = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[7],
                                        instr_i[30:25], instr_i[11:8], 1'b0};
            rv_isa_pkg::IMM_J: imm_o = {{(`RV_XLEN-20){instr_i[31]}}, instr_i[19:12],
                                        instr_i[20], instr_i[30:21], 1'b0};
            rv_isa_pkg::IMM_U: imm_o = {instr_i[31:12], 12'b0};
            default:           imm_o = '0;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
// Integer register file of the decode stage with two asynchronous reads and one write per clock
`timescale 1ns/100ps

`include "rv_params.svh"

module reg_file (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd2_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0]   wr_addr_i,
    input  logic [`RV_XLEN-1:0]         wr_data_i,
    input  logic                        wr_en_i,
    output logic [`RV_XLEN-1:0]         rd1_data_o,
    output logic [`RV_XLEN-1:0]         rd2_data_o
);

    logic [`RV_XLEN-1:0] regs_q [0:(1 << `RV_REG_ADDR_W)-1];

    always_ff @(posedge clk_i) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;  // x0 is never written
        end
    end

    // Same-cycle write still reads the old value
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs_q[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs_q[rd2_addr_i];

    // A nonzero write shows on both read ports from the next cycle on
    a_write_visible: assert property (@(posedge clk_i) disable iff (rst_i)
        (wr_en_i && wr_addr_i != '0) |=>
            ((rd1_addr_i != $past(wr_addr_i) || rd1_data_o == $past(wr_data_i)) &&
             (rd2_addr_i != $past(wr_addr_i) || rd2_data_o == $past(wr_data_i))))
        else $error("Register read missed the preceding write");

endmodule

// ==== logic/operand_unit.sv ====
// Forwarding muxes, PC and immediate selection and branch compare flags for the decode stage
`timescale 1ns/100ps

`include "rv_params.svh"

module operand_unit (
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    input  rv_pipe_pkg::fwd_sel_e   fwd_sel1_i,
    input  rv_pipe_pkg::fwd_sel_e   fwd_sel2_i,
    input  logic [`RV_XLEN-1:0]     exec_fwd_value_i,
    input  logic [`RV_XLEN-1:0]     wb_value_i,
    input  rv_pipe_pkg::opnd_src_e  opnd_src_i,
    input  logic [`RV_XLEN-1:0]     imm_i,
    input  logic [`RV_PC_W-1:0]     pc_i,
    output logic [`RV_XLEN-1:0]     value1_o,
    output logic [`RV_XLEN-1:0]     value2_o,
    output logic [`RV_XLEN-1:0]     store_data_o,
    output logic [2:0]              cmp_o
);

    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;
    logic [`RV_XLEN-1:0] pc_full;

    function automatic logic [`RV_XLEN-1:0] pick(input rv_pipe_pkg::fwd_sel_e sel,
                                                 input logic [`RV_XLEN-1:0] file_val);
        case (sel)
            rv_pipe_pkg::FWD_EXEC: return exec_fwd_value_i;
            rv_pipe_pkg::FWD_WB:   return wb_value_i;
            default:               return file_val;
        endcase
    endfunction

    assign src1 = pick(fwd_sel1_i, rs1_data_i);
    assign src2 = pick(fwd_sel2_i, rs2_data_i);

    // Base byte, zero gap, halfword PC, bit 0 clear
    assign pc_full = {`RV_PC_BASE_HI, {(`RV_XLEN-8-`RV_PC_W-1){1'b0}}, pc_i, 1'b0};

    assign value1_o = (opnd_src_i == rv_pipe_pkg::OPND_PC ||
                       opnd_src_i == rv_pipe_pkg::OPND_PCIMM) ? pc_full : src1;
    assign value2_o = (opnd_src_i == rv_pipe_pkg::OPND_IMM ||
                       opnd_src_i == rv_pipe_pkg::OPND_PCIMM) ? imm_i : src2;
    assign store_data_o = src2;  // Register value even when value2 is the offset

    // Signed less, unsigned less, equal
    assign cmp_o = {$signed(src1) < $signed(src2), src1 < src2, src1 == src2};

    always_comb begin
        assert (fwd_sel1_i !== 2'd3 && fwd_sel2_i !== 2'd3)
            else $error("Reserved forwarding select from hazard control");
    end

endmodule

// ==== logic/stage_register.sv ====
// Decode to execute pipeline register with stall hold and flush bubble insertion
`timescale 1ns/100ps

`include "rv_params.svh"

module stage_register (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    input  rv_isa_pkg::uop_e            uop_i,
    input  logic [`RV_XLEN-1:0]         value1_i,
    input  logic [`RV_XLEN-1:0]         value2_i,
    input  logic [`RV_XLEN-1:0]         store_data_i,
    input  logic [2:0]                  cmp_i,
    input  logic [`RV_PC_W-1:0]         pc_next_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd_addr_i,
    output rv_isa_pkg::uop_e            ex_uop_o,
    output logic [`RV_XLEN-1:0]         ex_value1_o,
    output logic [`RV_XLEN-1:0]         ex_value2_o,
    output logic [`RV_XLEN-1:0]         ex_store_data_o,
    output logic [2:0]                  ex_cmp_o,
    output logic [`RV_PC_W-1:0]         ex_pc_next_o,
    output logic [`RV_REG_ADDR_W-1:0]   ex_rd_addr_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_uop_o <= rv_isa_pkg::UOP_NOP;
            ex_cmp_o <= '0;
        end else if (!stall_i) begin
            ex_uop_o <= flush_i ? rv_isa_pkg::UOP_NOP : uop_i;  // Bubble on flush
            ex_cmp_o <= cmp_i;
        end
    end

    // Payload follows the same enable
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_value1_o     <= value1_i;
            ex_value2_o     <= value2_i;
            ex_store_data_o <= store_data_i;
            ex_pc_next_o    <= pc_next_i;  // Return address for JAL and JALR
            ex_rd_addr_o    <= rd_addr_i;
        end
    end

    a_flush_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
        (flush_i && !stall_i) |=> (ex_uop_o == rv_isa_pkg::UOP_NOP))
        else $error("Flush did not leave a bubble toward execute");

endmodule

// ==== logic/decode_stage.sv ====
// Decode and register-read stage top level, placed between fetch and execute of the pipeline
`timescale 1ns/100ps

`include "rv_params.svh"

module decode_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [31:0]                 instr_i,
    input  logic [`RV_PC_W-1:0]         pc_i,
    input  logic [`RV_PC_W-1:0]         pc_next_i,
    input  logic [`RV_XLEN-1:0]         exec_fwd_value_i,
    input  logic [`RV_REG_ADDR_W-1:0]   wb_addr_i,
    input  logic [`RV_XLEN-1:0]         wb_value_i,
    input  logic                        wb_we_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    input  rv_pipe_pkg::fwd_sel_e       fwd_sel1_i,
    input  rv_pipe_pkg::fwd_sel_e       fwd_sel2_i,
    output logic [`RV_REG_ADDR_W-1:0]   rs1_addr_o,   // To hazard control
    output logic [`RV_REG_ADDR_W-1:0]   rs2_addr_o,
    output rv_isa_pkg::uop_e            ex_uop_o,
    output logic [`RV_XLEN-1:0]         ex_value1_o,
    output logic [`RV_XLEN-1:0]         ex_value2_o,
    output logic [`RV_XLEN-1:0]         ex_store_data_o,
    output logic [2:0]                  ex_cmp_o,
    output logic [`RV_PC_W-1:0]         ex_pc_next_o,
    output logic [`RV_REG_ADDR_W-1:0]   ex_rd_addr_o
);

    rv_isa_pkg::uop_e           uop;
    rv_pipe_pkg::opnd_src_e     opnd_src;
    logic [`RV_XLEN-1:0]        imm;
    logic [`RV_REG_ADDR_W-1:0]  rd_addr;
    logic [`RV_XLEN-1:0]        rs1_data;
    logic [`RV_XLEN-1:0]        rs2_data;
    logic [`RV_XLEN-1:0]        value1;
    logic [`RV_XLEN-1:0]        value2;
    logic [`RV_XLEN-1:0]        store_data;
    logic [2:0]                 cmp;

    instr_decoder u_decoder (
        .instr_i    (instr_i),
        .uop_o      (uop),
        .opnd_src_o (opnd_src),
        .imm_o      (imm),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr)
    );

    reg_file u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd1_addr_i (rs1_addr_o),
        .rd2_addr_i (rs2_addr_o),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_value_i),
        .wr_en_i    (wb_we_i),
        .rd1_data_o (rs1_data),
        .rd2_data_o (rs2_data)
    );

    operand_unit u_operands (
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .fwd_sel1_i       (fwd_sel1_i),
        .fwd_sel2_i       (fwd_sel2_i),
        .exec_fwd_value_i (exec_fwd_value_i),
        .wb_value_i       (wb_value_i),
        .opnd_src_i       (opnd_src),
        .imm_i            (imm),
        .pc_i             (pc_i),
        .value1_o         (value1),
        .value2_o         (value2),
        .store_data_o     (store_data),
        .cmp_o            (cmp)
    );

    stage_register u_stage (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .uop_i           (uop),
        .value1_i        (value1),
        .value2_i        (value2),
        .store_data_i    (store_data),
        .cmp_i           (cmp),
        .pc_next_i       (pc_next_i),
        .rd_addr_i       (rd_addr),
        .ex_uop_o        (ex_uop_o),
        .ex_value1_o     (ex_value1_o),
        .ex_value2_o     (ex_value2_o),
        .ex_store_data_o (ex_store_data_o),
        .ex_cmp_o        (ex_cmp_o),
        .ex_pc_next_o    (ex_pc_next_o),
        .ex_rd_addr_o    (ex_rd_addr_o)
    );

endmodule

// ==== test/decode_stage_tb.sv ====
// Table-driven testbench for the decode stage that runs from the project root with all.f
`timescale 1ns/100ps

`include "rv_params.svh"

module decode_stage_tb;

    typedef struct {
        logic [31:0]                 instr;
        logic [`RV_PC_W-1:0]         pc;
        logic [`RV_PC_W-1:0]         pc_next;
        rv_pipe_pkg::fwd_sel_e       sel1;
        rv_pipe_pkg::fwd_sel_e       sel2;
        logic [`RV_XLEN-1:0]         exec_val;
        logic [`RV_REG_ADDR_W-1:0]   wb_addr;
        logic [`RV_XLEN-1:0]         wb_val;
        logic                        wb_we;
        logic                        stall;
        logic                        flush;
        rv_isa_pkg::uop_e            uop;   // Expected outputs from here on
        logic [`RV_XLEN-1:0]         v1;
        logic [`RV_XLEN-1:0]         v2;
        logic [`RV_XLEN-1:0]         sd;
        logic [2:0]                  cmp;
        logic [`RV_PC_W-1:0]         pcn;
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [`RV_REG_ADDR_W-1:0]   rs1;
        logic [`RV_REG_ADDR_W-1:0]   rs2;
    } row_t;

    logic                        clk_i;
    logic                        rst_i;
    logic [31:0]                 instr_i;
    logic [`RV_PC_W-1:0]         pc_i;
    logic [`RV_PC_W-1:0]         pc_next_i;
    logic [`RV_XLEN-1:0]         exec_fwd_value_i;
    logic [`RV_REG_ADDR_W-1:0]   wb_addr_i;
    logic [`RV_XLEN-1:0]         wb_value_i;
    logic                        wb_we_i;
    logic                        stall_i;
    logic                        flush_i;
    rv_pipe_pkg::fwd_sel_e       fwd_sel1_i;
    rv_pipe_pkg::fwd_sel_e       fwd_sel2_i;
    logic [`RV_REG_ADDR_W-1:0]   rs1_addr_o;
    logic [`RV_REG_ADDR_W-1:0]   rs2_addr_o;
    rv_isa_pkg::uop_e            ex_uop_o;
    logic [`RV_XLEN-1:0]         ex_value1_o;
    logic [`RV_XLEN-1:0]         ex_value2_o;
    logic [`RV_XLEN-1:0]         ex_store_data_o;
    logic [2:0]                  ex_cmp_o;
    logic [`RV_PC_W-1:0]         ex_pc_next_o;
    logic [`RV_REG_ADDR_W-1:0]   ex_rd_addr_o;

    row_t   rows[$];
    int     error_count;
    int     check_count;
    int     edge_count;
    realtime edge_time;
    logic   timed_out;

    decode_stage dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        edge_count = edge_count + 1;
        edge_time  = $realtime;
    end

    // Waits for the next rising edge and then moves to the given offset after it
    task automatic wait_edge_plus(input realtime offset);
        int start;
        int waited;
        start  = edge_count;
        waited = 0;
        while (edge_count == start && waited < 100) begin
            #1;
            waited++;
        end
        if (edge_count == start) begin
            $display("Timeout: no rising clock edge seen within 100 ns");
            timed_out = 1'b1;
        end else begin
            #(edge_time + offset - $realtime);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic add_row(input logic [31:0] instr, input logic [17:0] pc,
                           input logic [17:0] pcn_in, input rv_pipe_pkg::fwd_sel_e s1,
                           input rv_pipe_pkg::fwd_sel_e s2, input logic [31:0] ex,
                           input logic [4:0] wa, input logic [31:0] wv, input logic we,
                           input logic st, input logic fl, input rv_isa_pkg::uop_e uop,
                           input logic [31:0] v1, input logic [31:0] v2,
                           input logic [31:0] sd, input logic [2:0] cmp,
                           input logic [17:0] pcn, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        row_t r;
        r = '{instr, pc, pcn_in, s1, s2, ex, wa, wv, we, st, fl, uop, v1, v2, sd, cmp, pcn, rd,
              rs1, rs2};
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        instr_i          = r.instr;
        pc_i             = r.pc;
        pc_next_i        = r.pc_next;
        fwd_sel1_i       = r.sel1;
        fwd_sel2_i       = r.sel2;
        exec_fwd_value_i = r.exec_val;
        wb_addr_i        = r.wb_addr;
        wb_value_i       = r.wb_val;
        wb_we_i          = r.wb_we;
        stall_i          = r.stall;
        flush_i          = r.flush;
    endtask

    task automatic check_row(input row_t r);
        check_count++;
        assert (ex_uop_o == r.uop) else report_mismatch("uop", 32'(ex_uop_o), 32'(r.uop));
        assert (ex_value1_o === r.v1) else report_mismatch("value1", ex_value1_o, r.v1);
        assert (ex_value2_o === r.v2) else report_mismatch("value2", ex_value2_o, r.v2);
        assert (ex_store_data_o === r.sd)
            else report_mismatch("store data", ex_store_data_o, r.sd);
        assert (ex_cmp_o === r.cmp) else report_mismatch("cmp", 32'(ex_cmp_o), 32'(r.cmp));
        assert (ex_pc_next_o === r.pcn)
            else report_mismatch("pc next", 32'(ex_pc_next_o), 32'(r.pcn));
        assert (ex_rd_addr_o === r.rd)
            else report_mismatch("rd", 32'(ex_rd_addr_o), 32'(r.rd));
        assert (rs1_addr_o === r.rs1)
            else report_mismatch("rs1 addr", 32'(rs1_addr_o), 32'(r.rs1));
        assert (rs2_addr_o === r.rs2)
            else report_mismatch("rs2 addr", 32'(rs2_addr_o), 32'(r.rs2));
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        edge_count  = 0;
        edge_time   = 0.0;
        timed_out   = 1'b0;
        rst_i = 1'b1;
        apply_row('{32'h00000013, '0, '0, rv_pipe_pkg::FWD_NONE, rv_pipe_pkg::FWD_NONE,
                    '0, '0, '0, 1'b0, 1'b0, 1'b0, rv_isa_pkg::UOP_NOP, '0, '0, '0, '0, '0, '0,
                    '0, '0});

        // instr, pc, pc_next, sel1, sel2, exec, wb addr, wb value, we, stall, flush
        // then uop, value1, value2, store data, cmp, pc_next, rd, rs1, rs2
        add_row(32'h002083B3, 18'h00010, 18'h00011, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_ADD,
                32'd5, 32'd3, 32'd3, 3'b000, 18'h00011, 5'd7, 5'd1, 5'd2);
        add_row(32'h40208433, 18'h00011, 18'h00012, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_SUB,
                32'd5, 32'd3, 32'd3, 3'b000, 18'h00012, 5'd8, 5'd1, 5'd2);
        add_row(32'h001274B3, 18'h00012, 18'h00013, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_AND,
                32'd7, 32'd5, 32'd5, 3'b000, 18'h00013, 5'd9, 5'd4, 5'd1);
        add_row(32'h00000533, 18'h00013, 18'h00014, rv_pipe_pkg::FWD_NONE,  // Write to x0
                rv_pipe_pkg::FWD_NONE, 0, 0, 32'h0000DEAD, 1, 0, 0, rv_isa_pkg::UOP_ADD,
                32'd0, 32'd0, 32'd0, 3'b001, 18'h00014, 5'd10, 5'd0, 5'd0);
        add_row(32'h00000533, 18'h00014, 18'h00015, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_ADD,
                32'd0, 32'd0, 32'd0, 3'b001, 18'h00015, 5'd10, 5'd0, 5'd0);
        add_row(32'hFFC18593, 18'h00015, 18'h00016, rv_pipe_pkg::FWD_NONE,  // x3 vs x28
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_ADDI,
                32'hFFFFFFF0, 32'hFFFFFFFC, 32'h5A001C1C, 3'b100, 18'h00016, 5'd11, 5'd3, 5'd28);
        add_row(32'h0020A423, 18'h00016, 18'h00017, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_SW,
                32'd5, 32'd8, 32'd3, 3'b000, 18'h00017, 5'd8, 5'd1, 5'd2);
        add_row(32'hFE420CE3, 18'h00017, 18'h00018, rv_pipe_pkg::FWD_NONE,  // Branch on registers
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_BEQ,
                32'd7, 32'd7, 32'd7, 3'b001, 18'h00018, 5'd25, 5'd4, 5'd4);
        add_row(32'h001000EF, 18'h00100, 18'h00102, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_JAL,
                32'h40000200, 32'h00000800, 32'd5, 3'b110, 18'h00102, 5'd1, 5'd0, 5'd1);
        add_row(32'h12345637, 18'h00102, 18'h00103, rv_pipe_pkg::FWD_NONE,  // x8 vs x3
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_LUI,
                32'h5A000808, 32'h12345000, 32'hFFFFFFF0, 3'b010, 18'h00103, 5'd12, 5'd8, 5'd3);
        add_row(32'h00001697, 18'h3FFFF, 18'h00000, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_AUIPC,
                32'h4007FFFE, 32'h00001000, 32'd0, 3'b001, 18'h00000, 5'd13, 5'd0, 5'd0);
        add_row(32'h00208733, 18'h00020, 18'h00021, rv_pipe_pkg::FWD_EXEC,
                rv_pipe_pkg::FWD_WB, 32'hCAFE0001, 0, 32'h0BAD0000, 0, 0, 0,
                rv_isa_pkg::UOP_ADD, 32'hCAFE0001, 32'h0BAD0000, 32'h0BAD0000, 3'b100,
                18'h00021, 5'd14, 5'd1, 5'd2);
        add_row(32'h0020A423, 18'h00021, 18'h00022, rv_pipe_pkg::FWD_WB,
                rv_pipe_pkg::FWD_EXEC, 32'hCAFE0001, 0, 32'h0BAD0000, 0, 0, 0,
                rv_isa_pkg::UOP_SW, 32'h0BAD0000, 32'd8, 32'hCAFE0001, 3'b010,
                18'h00022, 5'd8, 5'd1, 5'd2);
        add_row(32'h006283B3, 18'h00022, 18'h00023, rv_pipe_pkg::FWD_NONE,  // x5 written now
                rv_pipe_pkg::FWD_NONE, 0, 5, 32'h00000077, 1, 0, 0, rv_isa_pkg::UOP_ADD,
                32'h00000010, 32'h12345678, 32'h12345678, 3'b110, 18'h00023, 5'd7, 5'd5, 5'd6);
        add_row(32'h006283B3, 18'h00023, 18'h00024, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_ADD,
                32'h00000077, 32'h12345678, 32'h12345678, 3'b110, 18'h00024, 5'd7, 5'd5, 5'd6);
        add_row(32'h40208433, 18'h00024, 18'h00025, rv_pipe_pkg::FWD_NONE,  // Stalled so held
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 1, 0, rv_isa_pkg::UOP_ADD,
                32'h00000077, 32'h12345678, 32'h12345678, 3'b110, 18'h00024, 5'd7, 5'd1, 5'd2);
        add_row(32'h002083B3, 18'h00025, 18'h00026, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 1, rv_isa_pkg::UOP_NOP,
                32'd5, 32'd3, 32'd3, 3'b000, 18'h00026, 5'd7, 5'd1, 5'd2);
        add_row(32'h0000007F, 18'h00026, 18'h00027, rv_pipe_pkg::FWD_NONE,
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_ILLEGAL,
                32'd0, 32'd0, 32'd0, 3'b001, 18'h00027, 5'd0, 5'd0, 5'd0);
        add_row(32'h00000073, 18'h00027, 18'h00028, rv_pipe_pkg::FWD_NONE,  // ECALL
                rv_pipe_pkg::FWD_NONE, 0, 0, 0, 0, 0, 0, rv_isa_pkg::UOP_NOP,
                32'd0, 32'd0, 32'd0, 3'b001, 18'h00028, 5'd0, 5'd0, 5'd0);

        wait_edge_plus(2.0);
        if (!timed_out) wait_edge_plus(2.0);
        rst_i = 1'b0;
        check_count++;
        assert (ex_uop_o == rv_isa_pkg::UOP_NOP && ex_cmp_o == 3'b000)
            else report_mismatch("reset uop and cmp", {26'd0, ex_cmp_o, 3'd0}, 32'd0);

        // Preload through write-back with an address-derived pattern from x7 up
        for (int a = 1; a < 32 && !timed_out; a++) begin
            wb_addr_i = a[4:0];
            case (a)
                1: wb_value_i = 32'd5;
                2: wb_value_i = 32'd3;
                3: wb_value_i = 32'hFFFFFFF0;
                4: wb_value_i = 32'd7;
                5: wb_value_i = 32'h00000010;
                6: wb_value_i = 32'h12345678;
                default: wb_value_i = 32'h5A000000 | (32'(a) << 8) | 32'(a);
            endcase
            wb_we_i = 1'b1;
            wait_edge_plus(2.0);
        end
        wb_we_i = 1'b0;

        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(rows[i]);
                wait_edge_plus(1.0);
                if (!timed_out) check_row(rows[i]);
                #1;
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_unit.sv
logic/stage_register.sv
logic/decode_stage.sv
test/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= decode_stage_tb
FILELIST  ?= all.f

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
